/* filelist.f */
hw/box_geom_pkg.sv
hw/scan_ctrl_pkg.sv
hw/line_buffer.sv
hw/window_sum.sv
hw/scan_ctrl.sv
hw/threshold_unit.sv
hw/box_threshold_top.sv
testbench/tb_box_threshold.sv

/* hw/box_geom_pkg.sv */
package box_geom_pkg;

  // grayscale pixel
  localparam int PIX_W = 8;

  // side of the square window
  localparam int WIN = 5;

  // five pixels of one column, 5 * 255 = 1275
  localparam int COL_SUM_W = 11;

  // twenty-five pixels of the window, 25 * 255 = 6375
  localparam int BOX_SUM_W = 13;

  // column and row position inside a frame
  localparam int CNT_W = 10;

  localparam int unsigned MAX_BOX_SUM = WIN * WIN * ((1 << PIX_W) - 1);

endpackage

/* hw/box_threshold_top.sv */
`timescale 1ns/1ps

module box_threshold_top #(
  parameter int COLS = 8,
  parameter int ROWS = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_valid,
  input  logic                               i_sof,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_pixel,
  input  logic [box_geom_pkg::BOX_SUM_W-1:0] i_offset,
  output logic                               o_valid,
  output logic [box_geom_pkg::BOX_SUM_W-1:0] o_sum,
  output logic [box_geom_pkg::PIX_W-1:0]     o_center,
  output logic                               o_bin
);

  logic [box_geom_pkg::PIX_W-1:0]     col_0;
  logic [box_geom_pkg::PIX_W-1:0]     col_1;
  logic [box_geom_pkg::PIX_W-1:0]     col_2;
  logic [box_geom_pkg::PIX_W-1:0]     col_3;
  logic [box_geom_pkg::PIX_W-1:0]     col_4;
  logic                               col_valid;
  logic                               count_en;
  logic                               sum_en;
  logic                               sub_en;
  logic                               load_en;
  logic                               clear;
  logic                               win_valid;
  logic                               col_last;
  logic                               rows_ready;
  logic [box_geom_pkg::BOX_SUM_W-1:0] box_sum;
  logic [box_geom_pkg::PIX_W-1:0]     center;

  line_buffer #(
    .COLS (COLS)
  ) u_line_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_sof       (i_sof),
    .i_pixel     (i_pixel),
    .o_col_0     (col_0),
    .o_col_1     (col_1),
    .o_col_2     (col_2),
    .o_col_3     (col_3),
    .o_col_4     (col_4),
    .o_col_valid (col_valid)
  );

  window_sum #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) u_window_sum (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_col_valid  (col_valid),
    .i_col_0      (col_0),
    .i_col_1      (col_1),
    .i_col_2      (col_2),
    .i_col_3      (col_3),
    .i_col_4      (col_4),
    .i_count_en   (count_en),
    .i_sum_en     (sum_en),
    .i_sub_en     (sub_en),
    .i_load_en    (load_en),
    .i_clear      (clear),
    .o_box_sum    (box_sum),
    .o_center     (center),
    .o_col_last   (col_last),
    .o_rows_ready (rows_ready)
  );

  scan_ctrl #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) u_scan_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_valid      (i_valid),
    .i_sof        (i_sof),
    .i_col_last   (col_last),
    .i_rows_ready (rows_ready),
    .o_count_en   (count_en),
    .o_sum_en     (sum_en),
    .o_sub_en     (sub_en),
    .o_load_en    (load_en),
    .o_clear      (clear),
    .o_win_valid  (win_valid)
  );

  threshold_unit u_threshold_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_win_valid (win_valid),
    .i_box_sum   (box_sum),
    .i_center    (center),
    .i_offset    (i_offset),
    .o_valid     (o_valid),
    .o_sum       (o_sum),
    .o_center    (o_center),
    .o_bin       (o_bin)
  );

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer #(
  parameter int COLS = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           i_valid,
  input  logic                           i_sof,
  input  logic [box_geom_pkg::PIX_W-1:0] i_pixel,
  output logic [box_geom_pkg::PIX_W-1:0] o_col_0,
  output logic [box_geom_pkg::PIX_W-1:0] o_col_1,
  output logic [box_geom_pkg::PIX_W-1:0] o_col_2,
  output logic [box_geom_pkg::PIX_W-1:0] o_col_3,
  output logic [box_geom_pkg::PIX_W-1:0] o_col_4,
  output logic                           o_col_valid
);

  localparam int PW    = box_geom_pkg::PIX_W;
  localparam int DEPTH = box_geom_pkg::WIN - 1;
  localparam int AW    = (COLS > 1) ? $clog2(COLS) : 1;

  logic [PW-1:0] row_mem [DEPTH][COLS];  // row_mem[0] is the row just above
  logic [AW-1:0] wr_col;
  logic [AW-1:0] col_idx;

  assign col_idx = i_sof ? '0 : wr_col;  // the first pixel of a frame is column 0

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_col <= '0;
    end else if (i_valid) begin
      wr_col <= (col_idx == AW'(COLS - 1)) ? '0 : col_idx + 1'b1;
    end
  end

  // each pixel pushes its column one row down and drops the oldest row
  always_ff @(posedge clk) begin
    if (i_valid) begin
      row_mem[0][col_idx] <= i_pixel;
      for (int k = 1; k < DEPTH; k++) begin
        row_mem[k][col_idx] <= row_mem[k-1][col_idx];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_col_4 <= i_pixel;
      o_col_3 <= row_mem[0][col_idx];
      o_col_2 <= row_mem[1][col_idx];
      o_col_1 <= row_mem[2][col_idx];
      o_col_0 <= row_mem[3][col_idx];  // oldest row of the window
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= i_valid;
    end
  end

  a_sof_in_stream : assert property (@(posedge clk) disable iff (!rst_n)
    i_sof |-> i_valid);

endmodule

/* hw/scan_ctrl.sv */
`timescale 1ns/1ps

module scan_ctrl #(
  parameter int COLS = 8,
  parameter int ROWS = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_valid,
  input  logic i_sof,
  input  logic i_col_last,
  input  logic i_rows_ready,
  output logic o_count_en,
  output logic o_sum_en,
  output logic o_sub_en,
  output logic o_load_en,
  output logic o_clear,
  output logic o_win_valid
);

  localparam int WIN        = box_geom_pkg::WIN;
  localparam int FRAME_WINS = (ROWS - WIN + 1) * (COLS - WIN + 1);
  localparam int WC_W       = 2 * box_geom_pkg::CNT_W;
  localparam int FILL_W     = $clog2(WIN + 1);
  localparam int DLY        = scan_ctrl_pkg::SUM_PIPE_DEPTH;
  localparam int WDLY       = scan_ctrl_pkg::WIN_DELAY;
  localparam int DRAIN_W    = $clog2(WDLY);

  scan_ctrl_pkg::scan_state_e state;
  scan_ctrl_pkg::scan_state_e state_nxt;

  logic              col_v;      // a column is at the window_sum input
  logic [FILL_W-1:0] fill_cnt;   // columns of the current row, saturates at WIN
  logic [WC_W-1:0]   win_cnt;
  logic [DRAIN_W-1:0] drain_cnt;
  logic              load_in;
  logic              sub_in;
  logic              win_in;
  logic              last_win;
  logic              drain_done;
  logic [2:0]        ctl_pipe [DLY];
  logic              win_pipe [WDLY];

  assign o_clear    = i_sof;  // counters restart one cycle ahead of column 0
  assign o_count_en = (state != scan_ctrl_pkg::IDLE);

  assign load_in    = col_v && (fill_cnt == '0);
  assign sub_in     = col_v && (fill_cnt == FILL_W'(WIN));
  assign win_in     = col_v && (state == scan_ctrl_pkg::RUN) && i_rows_ready &&
                      (fill_cnt >= FILL_W'(WIN - 1));
  assign last_win   = (win_cnt == WC_W'(FRAME_WINS - 1));
  assign drain_done = (drain_cnt == DRAIN_W'(WDLY - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_v <= 1'b0;
    end else begin
      col_v <= i_valid;
    end
  end

  always_comb begin
    state_nxt = state;
    if (i_sof) begin
      state_nxt = scan_ctrl_pkg::FILL;  // also restarts a frame that is still running
    end else begin
      case (state)
        scan_ctrl_pkg::IDLE: state_nxt = scan_ctrl_pkg::IDLE;
        scan_ctrl_pkg::FILL: begin
          if (col_v && i_rows_ready) begin
            state_nxt = scan_ctrl_pkg::RUN;
          end
        end
        scan_ctrl_pkg::RUN: begin
          if (win_in && last_win) begin
            state_nxt = scan_ctrl_pkg::DRAIN;
          end
        end
        scan_ctrl_pkg::DRAIN: begin
          if (drain_done) begin
            state_nxt = scan_ctrl_pkg::IDLE;
          end
        end
        default: state_nxt = scan_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= scan_ctrl_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_cnt <= '0;
      win_cnt  <= '0;
    end else if (i_sof) begin
      fill_cnt <= '0;
      win_cnt  <= '0;
    end else if (col_v) begin
      if (i_col_last) begin
        fill_cnt <= '0;
      end else if (fill_cnt != FILL_W'(WIN)) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (win_in) begin
        win_cnt <= last_win ? '0 : win_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drain_cnt <= '0;
    end else if (state == scan_ctrl_pkg::DRAIN) begin
      drain_cnt <= drain_cnt + 1'b1;
    end else begin
      drain_cnt <= '0;
    end
  end

  // enables meet the column at the running-sum adder, the flag meets the box sum
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DLY; k++) begin
        ctl_pipe[k] <= '0;
      end
      for (int k = 0; k < WDLY; k++) begin
        win_pipe[k] <= 1'b0;
      end
    end else begin
      ctl_pipe[0] <= {col_v, sub_in, load_in};
      for (int k = 1; k < DLY; k++) begin
        ctl_pipe[k] <= ctl_pipe[k-1];
      end
      win_pipe[0] <= win_in;
      for (int k = 1; k < WDLY; k++) begin
        win_pipe[k] <= win_pipe[k-1];
      end
    end
  end

  assign {o_sum_en, o_sub_en, o_load_en} = ctl_pipe[DLY-1];
  assign o_win_valid = win_pipe[WDLY-1];

  // DRAIN has to outlast the flag delay line
  a_no_win_in_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (state == scan_ctrl_pkg::IDLE) |-> !o_win_valid);

endmodule

/* hw/scan_ctrl_pkg.sv */
package scan_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,   // waiting for a start of frame
    FILL,   // first four rows going into the line buffer
    RUN,    // full-height columns, windows are produced
    DRAIN   // last pixel in, results still in flight
  } scan_state_e;

  // input register, two adder levels, fifth-pixel add and two column-sum taps
  // bring a column to the running-sum adder after this many cycles
  localparam int SUM_PIPE_DEPTH = 6;

  // the running-sum register adds one more cycle before the box sum is seen
  localparam int WIN_DELAY = SUM_PIPE_DEPTH + 1;

endpackage

/* hw/threshold_unit.sv */
`timescale 1ns/1ps

module threshold_unit (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_win_valid,
  input  logic [box_geom_pkg::BOX_SUM_W-1:0] i_box_sum,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_center,
  input  logic [box_geom_pkg::BOX_SUM_W-1:0] i_offset,
  output logic                               o_valid,
  output logic [box_geom_pkg::BOX_SUM_W-1:0] o_sum,
  output logic [box_geom_pkg::PIX_W-1:0]     o_center,
  output logic                               o_bin
);

  localparam int SW = box_geom_pkg::BOX_SUM_W;
  localparam logic [SW:0] MAX_REF = (SW + 1)'(box_geom_pkg::MAX_BOX_SUM);

  logic [SW-1:0] center_ext;
  logic [SW-1:0] center_x25;
  logic [SW:0]   ref_raw;
  logic [SW-1:0] ref_sat;
  logic          bin_nxt;

  assign center_ext = SW'(i_center);
  assign center_x25 = (center_ext << 4) + (center_ext << 3) + center_ext;  // 16c + 8c + c
  assign ref_raw    = {1'b0, i_box_sum} + {1'b0, i_offset};

  // 25 * centre never exceeds MAX_BOX_SUM, so clamping the reference keeps the answer
  assign ref_sat = (ref_raw > MAX_REF) ? MAX_REF[SW-1:0] : ref_raw[SW-1:0];
  assign bin_nxt = (center_x25 > ref_sat);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_win_valid;
    end
  end

  always_ff @(posedge clk) begin
    o_sum    <= i_box_sum;
    o_center <= i_center;
    o_bin    <= bin_nxt;
  end

endmodule

/* hw/window_sum.sv */
`timescale 1ns/1ps

module window_sum #(
  parameter int COLS = 8,
  parameter int ROWS = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_col_valid,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_col_0,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_col_1,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_col_2,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_col_3,
  input  logic [box_geom_pkg::PIX_W-1:0]     i_col_4,
  input  logic                               i_count_en,
  input  logic                               i_sum_en,
  input  logic                               i_sub_en,
  input  logic                               i_load_en,
  input  logic                               i_clear,
  output logic [box_geom_pkg::BOX_SUM_W-1:0] o_box_sum,
  output logic [box_geom_pkg::PIX_W-1:0]     o_center,
  output logic                               o_col_last,
  output logic                               o_rows_ready
);

  localparam int PW  = box_geom_pkg::PIX_W;
  localparam int CSW = box_geom_pkg::COL_SUM_W;
  localparam int SW  = box_geom_pkg::BOX_SUM_W;
  localparam int CW  = box_geom_pkg::CNT_W;
  localparam int WIN = box_geom_pkg::WIN;

  // input register, two adder levels and the fifth-pixel add
  localparam int TREE_STAGES  = 4;
  localparam int CUR_TAP      = scan_ctrl_pkg::SUM_PIPE_DEPTH - TREE_STAGES - 1;
  localparam int OLD_TAP      = CUR_TAP + WIN;
  localparam int HIST_DEPTH   = OLD_TAP + 1;
  // the centre column entered WIN/2 columns before the one that closes the window
  localparam int CENTER_DELAY = scan_ctrl_pkg::WIN_DELAY + WIN / 2;

  logic [CW-1:0]   col_cnt;
  logic [CW-1:0]   row_cnt;
  logic            col_step;
  logic [PW-1:0]   px0, px1, px2, px3, px4;
  logic [PW:0]     s01, s23;
  logic [PW+1:0]   s0123;
  logic [PW-1:0]   p4_d1, p4_d2;
  logic [CSW-1:0]  col_sum_q;
  logic [CSW-1:0]  cs_hist [HIST_DEPTH];
  logic [SW-1:0]   run_sum;
  logic [SW-1:0]   run_base;
  logic [SW-1:0]   cur_ext;
  logic [SW-1:0]   old_ext;
  logic [PW-1:0]   ctr_pipe [CENTER_DELAY];

  assign col_step     = i_count_en && i_col_valid;
  assign o_col_last   = (col_cnt == CW'(COLS - 1));
  assign o_rows_ready = (row_cnt >= CW'(WIN - 1));  // four rows already sit in the line buffer

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (i_clear) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (col_step) begin
      if (o_col_last) begin
        col_cnt <= '0;
        row_cnt <= (row_cnt == CW'(ROWS - 1)) ? '0 : row_cnt + 1'b1;
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    px0 <= i_col_0;
    px1 <= i_col_1;
    px2 <= i_col_2;
    px3 <= i_col_3;
    px4 <= i_col_4;
  end

  always_ff @(posedge clk) begin
    s01   <= (PW+1)'(px0) + (PW+1)'(px1);
    s23   <= (PW+1)'(px2) + (PW+1)'(px3);
    p4_d1 <= px4;
    s0123 <= (PW+2)'(s01) + (PW+2)'(s23);
    p4_d2 <= p4_d1;
    col_sum_q <= CSW'(s0123) + CSW'(p4_d2);
  end

  // free-running history, columns of a frame arrive on consecutive cycles
  always_ff @(posedge clk) begin
    cs_hist[0] <= col_sum_q;
    for (int k = 1; k < HIST_DEPTH; k++) begin
      cs_hist[k] <= cs_hist[k-1];
    end
  end

  assign cur_ext  = SW'(cs_hist[CUR_TAP]);
  assign old_ext  = i_sub_en ? SW'(cs_hist[OLD_TAP]) : '0;
  assign run_base = i_load_en ? '0 : run_sum;

  // not touched by i_clear, the last windows of the previous frame may still be summing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_sum <= '0;
    end else if (i_sum_en) begin
      run_sum <= run_base + cur_ext - old_ext;
    end
  end

  assign o_box_sum = run_sum;

  always_ff @(posedge clk) begin
    ctr_pipe[0] <= i_col_2;  // middle row of the column
    for (int k = 1; k < CENTER_DELAY; k++) begin
      ctr_pipe[k] <= ctr_pipe[k-1];
    end
  end

  assign o_center = ctr_pipe[CENTER_DELAY-1];

  // holds only if load and subtract arrive from scan_ctrl on the right columns
  a_box_sum_range : assert property (@(posedge clk) disable iff (!rst_n)
    o_box_sum <= box_geom_pkg::MAX_BOX_SUM);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f filelist.f --top-module tb_box_threshold -o sim_box_threshold; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_box_threshold)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1

/* testbench/tb_box_threshold.sv */
`timescale 1ns/1ps

module tb_box_threshold;

  localparam int COLS           = 8;
  localparam int ROWS           = 8;
  localparam int WIN            = 5;
  localparam int NUM_FRAMES     = 4;
  localparam int WINS           = (COLS - WIN + 1) * (ROWS - WIN + 1);
  localparam int FRAME_WORDS    = 1 + COLS * ROWS + 3 * WINS;
  localparam int RESET_CYCLES   = 10;
  localparam int QUIET_CYCLES   = 20;
  localparam int LATENCY        = 9;  // line buffer 1, window sum 7 and threshold 1
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * (COLS * ROWS + 20) + RESET_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        i_valid;
  logic        i_sof;
  logic [7:0]  i_pixel;
  logic [12:0] i_offset;
  logic        o_valid;
  logic [12:0] o_sum;
  logic [7:0]  o_center;
  logic        o_bin;

  logic [15:0] cases_mem [NUM_FRAMES * FRAME_WORDS];
  int          exp_sum_q [$];
  int          exp_ctr_q [$];
  int          exp_bin_q [$];
  int          exp_frame_q [$];
  int          exp_win_q [$];
  int          exp_cyc_q [$];
  int          results [NUM_FRAMES];
  int          frame_errs [NUM_FRAMES];
  string       frame_names [NUM_FRAMES];
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          seed;

  box_threshold_top #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_valid  (i_valid),
    .i_sof    (i_sof),
    .i_pixel  (i_pixel),
    .i_offset (i_offset),
    .o_valid  (o_valid),
    .o_sum    (o_sum),
    .o_center (o_center),
    .o_bin    (o_bin)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // a result is only legal once the pixel that closes its window has been sent
  task automatic check_outputs();
    int f;
    int w;
    int sent;
    int errs_before;
    if (o_valid === 1'b1) begin
      if (exp_sum_q.size() == 0) begin
        errors++;
        $display("unexpected result at %0t ns: o_valid is high with no window pending", $time);
      end else begin
        f = exp_frame_q.pop_front();
        w = exp_win_q.pop_front();
        sent = exp_cyc_q.pop_front();
        errs_before = errors;
        check_value($sformatf("frame %0d window %0d latency", f, w), cycle_cnt - sent,
                    LATENCY);
        check_value($sformatf("frame %0d window %0d sum", f, w), o_sum, exp_sum_q.pop_front());
        check_value($sformatf("frame %0d window %0d centre", f, w), o_center,
                    exp_ctr_q.pop_front());
        check_value($sformatf("frame %0d window %0d bit", f, w), o_bin, exp_bin_q.pop_front());
        frame_errs[f] += errors - errs_before;
        results[f]++;
        if (results[f] == WINS) begin
          $display("frame %0d (%s): %0d results, %0d mismatches", f, frame_names[f],
                   results[f], frame_errs[f]);
        end
      end
    end
  endtask

  // outputs are sampled mid-cycle and inputs change right after
  task automatic tick();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic idle_cycles(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      tick();
      i_valid = 1'b0;
      i_sof   = 1'b0;
      i_pixel = '0;
    end
  endtask

  task automatic send_frame(input int f);
    int base;
    int p;
    int r;
    int c;
    int w;
    base = f * FRAME_WORDS;
    for (p = 0; p < COLS * ROWS; p++) begin
      tick();
      r = p / COLS;
      c = p % COLS;
      i_valid  = 1'b1;
      i_sof    = (p == 0);
      i_offset = cases_mem[base][12:0];
      i_pixel  = cases_mem[base + 1 + p][7:0];
      if (r >= WIN - 1 && c >= WIN - 1) begin  // this pixel is the bottom right of a window
        w = (r - WIN + 1) * (COLS - WIN + 1) + (c - WIN + 1);
        exp_frame_q.push_back(f);
        exp_win_q.push_back(w);
        exp_cyc_q.push_back(cycle_cnt);
        exp_sum_q.push_back(cases_mem[base + 1 + COLS * ROWS + 3 * w]);
        exp_ctr_q.push_back(cases_mem[base + 2 + COLS * ROWS + 3 * w]);
        exp_bin_q.push_back(cases_mem[base + 3 + COLS * ROWS + 3 * w]);
      end
    end
  endtask

  initial begin
    int f;
    int gap;
    seed     = 28098;
    rst_n    = 1'b0;
    i_valid  = 1'b0;
    i_sof    = 1'b0;
    i_pixel  = '0;
    i_offset = '0;
    for (f = 0; f < NUM_FRAMES; f++) begin
      results[f]    = 0;
      frame_errs[f] = 0;
    end
    frame_names[0] = "flat";
    frame_names[1] = "horizontal ramp";
    frame_names[2] = "vertical ramp";
    frame_names[3] = "sparse spots with offset";

    $readmemh("testbench/threshold_cases.txt", cases_mem);
    if ($isunknown(cases_mem[1]) || cases_mem[1] == '0) begin  // first pixel of the flat frame is never zero
      errors++;
      $display("the cases file testbench/threshold_cases.txt could not be read");
    end

    repeat (RESET_CYCLES) tick();
    rst_n = 1'b1;
    idle_cycles(2);

    // gaps of zero to five cycles let a new i_sof land while the last frame drains
    for (f = 0; f < NUM_FRAMES; f++) begin
      if (f > 0) begin
        gap = {$random(seed)} % 6;
        idle_cycles(gap);
      end
      send_frame(f);
    end
    idle_cycles(1);

    while (exp_sum_q.size() != 0) begin
      tick();
    end
    idle_cycles(QUIET_CYCLES);  // nothing may come out after the drain

    $display("summary: %0d frames, %0d checks, %0d errors", NUM_FRAMES, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* testbench/threshold_cases.txt */
// per frame: the offset, then 8 pixel rows of 8 pixels, then 4 rows of expected results
// each result is a triple of box sum, centre pixel and foreground bit, in raster order
// frame 0: flat frame of 0x50, offset 0
0
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
50 50 50 50 50 50 50 50
7D0 50 0 7D0 50 0 7D0 50 0 7D0 50 0
7D0 50 0 7D0 50 0 7D0 50 0 7D0 50 0
7D0 50 0 7D0 50 0 7D0 50 0 7D0 50 0
7D0 50 0 7D0 50 0 7D0 50 0 7D0 50 0
// frame 1: horizontal ramp 16 * col + 8, offset 0
0
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
08 18 28 38 48 58 68 78
3E8 28 0 578 38 0 708 48 0 898 58 0
3E8 28 0 578 38 0 708 48 0 898 58 0
3E8 28 0 578 38 0 708 48 0 898 58 0
3E8 28 0 578 38 0 708 48 0 898 58 0
// frame 2: vertical ramp 16 * row + 8, offset 0
0
08 08 08 08 08 08 08 08
18 18 18 18 18 18 18 18
28 28 28 28 28 28 28 28
38 38 38 38 38 38 38 38
48 48 48 48 48 48 48 48
58 58 58 58 58 58 58 58
68 68 68 68 68 68 68 68
78 78 78 78 78 78 78 78
3E8 28 0 3E8 28 0 3E8 28 0 3E8 28 0
578 38 0 578 38 0 578 38 0 578 38 0
708 48 0 708 48 0 708 48 0 708 48 0
898 58 0 898 58 0 898 58 0 898 58 0
// frame 3: background 0x10 with six spots, offset 385 puts window 0 exactly on the threshold
181
FF 10 10 10 10 10 10 10
10 10 10 10 10 10 10 10
10 10 30 10 10 10 10 10
10 10 10 10 10 04 10 10
10 10 10 A0 10 10 10 10
10 10 10 10 10 10 70 10
10 10 10 10 10 10 10 10
10 10 10 10 10 10 10 20
32F 30 0 234 10 0 234 10 0 214 10 0
240 10 0 234 10 0 294 10 0 274 04 0
240 10 0 234 A0 1 294 10 0 274 10 0
220 10 0 214 10 0 274 10 0 284 10 0
